// File: rtl/read_guard_pkg.sv
`default_nettype none

package read_guard_pkg;

  localparam int unsigned ID_W   = 4;
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned LEN_W  = 8;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned CNT_W  = 16;

  typedef logic [ID_W-1:0]   id_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [LEN_W-1:0]  len_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [CNT_W-1:0]  cnt_t;

  // Life cycle of one read in the slot table
  typedef enum logic [1:0] {
    SLOT_FREE,
    SLOT_ADDR,
    SLOT_DATA
  } txn_state_e;

  typedef enum logic [1:0] {
    CAUSE_NONE,
    CAUSE_ADDR_TIMEOUT,
    CAUSE_DATA_TIMEOUT,
    CAUSE_UNWANTED_RSP
  } guard_cause_e;

  // Index width that stays valid for a single entry
  function automatic int unsigned idx_width(input int unsigned n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

endpackage

`default_nettype wire

// File: rtl/slot_timer_if.sv
`timescale 1ns/100ps
`default_nettype none

interface slot_timer_if #(
  parameter int unsigned MaxRdTxns = 4
);
  import read_guard_pkg::*;

  // Slot view owned by the table
  txn_state_e           state [MaxRdTxns];
  len_t [MaxRdTxns-1:0] len;
  logic [MaxRdTxns-1:0] alloc;
  logic [MaxRdTxns-1:0] first_beat;

  // Flags owned by the timer
  logic [MaxRdTxns-1:0] timeout;
  logic [MaxRdTxns-1:0] timeout_data;

  modport table_mp (output state, len, alloc, first_beat);

  modport timer_mp (input state, len, alloc, first_beat, output timeout, timeout_data);

endinterface

`default_nettype wire

// File: rtl/txn_table.sv
`timescale 1ns/100ps
`default_nettype none

module txn_table #(
  parameter int unsigned MaxRdTxns  = 4,
  parameter int unsigned MaxUniqIds = 4
) (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            ar_fire_i,
  input  read_guard_pkg::id_t                             ar_id_i,
  input  read_guard_pkg::addr_t                           ar_addr_i,
  input  read_guard_pkg::len_t                            ar_len_i,
  input  logic                                            r_fire_i,
  input  read_guard_pkg::id_t                             r_id_i,
  input  logic                                            r_last_i,
  input  logic                                            flush_i,
  input  logic [read_guard_pkg::idx_width(MaxRdTxns)-1:0] timeout_slot_i,
  output logic                                            full_o,
  output logic                                            unwanted_o,
  output read_guard_pkg::addr_t                           slot_addr_o,
  slot_timer_if.table_mp                                  timer_o
);
  import read_guard_pkg::*;

  // Never more live IDs than slots
  localparam int unsigned HtCap = (MaxUniqIds < MaxRdTxns) ? MaxUniqIds : MaxRdTxns;
  localparam int unsigned SlotW = idx_width(MaxRdTxns);
  localparam int unsigned HtW   = idx_width(HtCap);

  // Linked slot array
  txn_state_e                      state_q [MaxRdTxns];
  txn_state_e                      state_d [MaxRdTxns];
  logic [MaxRdTxns-1:0][SlotW-1:0] next_q, next_d;
  id_t   [MaxRdTxns-1:0]           slot_id_q;
  addr_t [MaxRdTxns-1:0]           addr_q;
  len_t  [MaxRdTxns-1:0]           len_q;

  // Head-tail table, one entry per live ID
  logic [HtCap-1:0]                ht_used_q, ht_used_d;
  id_t  [HtCap-1:0]                ht_id_q, ht_id_d;
  logic [HtCap-1:0][SlotW-1:0]     ht_head_q, ht_head_d;
  logic [HtCap-1:0][SlotW-1:0]     ht_tail_q, ht_tail_d;

  logic [MaxRdTxns-1:0]            slot_free_q;
  logic                            r_hit, ar_known;
  logic [HtW-1:0]                  r_ht;
  logic [SlotW-1:0]                r_head;
  logic                            alloc_we;
  logic [SlotW-1:0]                alloc_idx;
  logic [MaxRdTxns-1:0]            alloc_vec, first_beat;

  // Lookups on the registered table
  always_comb begin
    r_hit    = 1'b0;
    r_ht     = '0;
    ar_known = 1'b0;
    for (int h = 0; h < HtCap; h++) begin
      if (!r_hit && ht_used_q[h] && ht_id_q[h] == r_id_i) begin
        r_hit = 1'b1;
        r_ht  = HtW'(h);
      end
      if (ht_used_q[h] && ht_id_q[h] == ar_id_i) begin
        ar_known = 1'b1;
      end
    end
    for (int s = 0; s < MaxRdTxns; s++) begin
      slot_free_q[s] = (state_q[s] == SLOT_FREE);
    end
  end

  assign r_head      = ht_head_q[r_ht];
  assign unwanted_o  = r_fire_i && !r_hit;
  // No slot left, or a new ID with no head-tail entry left
  assign full_o      = !(|slot_free_q) || (!ar_known && (&ht_used_q));
  assign slot_addr_o = addr_q[timeout_slot_i];

  always_comb begin
    logic           slot_found, ht_found, ar_hit;
    logic [HtW-1:0] ar_ht, free_ht;
    state_d    = state_q;
    next_d     = next_q;
    ht_used_d  = ht_used_q;
    ht_id_d    = ht_id_q;
    ht_head_d  = ht_head_q;
    ht_tail_d  = ht_tail_q;
    first_beat = '0;
    alloc_vec  = '0;
    alloc_we   = 1'b0;
    alloc_idx  = '0;
    slot_found = 1'b0;
    ht_found   = 1'b0;
    ar_hit     = 1'b0;
    ar_ht      = '0;
    free_ht    = '0;

    // R beat acts on the oldest read of its ID
    if (r_fire_i && r_hit) begin
      if (state_q[r_head] == SLOT_ADDR) begin
        state_d[r_head]    = SLOT_DATA;
        first_beat[r_head] = 1'b1;
      end
      if (r_last_i) begin
        state_d[r_head] = SLOT_FREE;
        if (r_head == ht_tail_q[r_ht]) begin
          ht_used_d[r_ht] = 1'b0;
        end else begin
          ht_head_d[r_ht] = next_q[r_head];
        end
      end
    end

    // Allocation sees the table after retirement, so freed entries are reused
    if (ar_fire_i) begin
      for (int s = 0; s < MaxRdTxns; s++) begin
        if (!slot_found && state_d[s] == SLOT_FREE) begin
          slot_found = 1'b1;
          alloc_idx  = SlotW'(s);
        end
      end
      for (int h = 0; h < HtCap; h++) begin
        if (!ar_hit && ht_used_d[h] && ht_id_d[h] == ar_id_i) begin
          ar_hit = 1'b1;
          ar_ht  = HtW'(h);
        end
        if (!ht_found && !ht_used_d[h]) begin
          ht_found = 1'b1;
          free_ht  = HtW'(h);
        end
      end
      if (slot_found && (ar_hit || ht_found)) begin
        alloc_we             = 1'b1;
        alloc_vec[alloc_idx] = 1'b1;
        state_d[alloc_idx]   = SLOT_ADDR;
        if (ar_hit) begin
          // Append behind the current tail of this ID
          next_d[ht_tail_d[ar_ht]] = alloc_idx;
          ht_tail_d[ar_ht]         = alloc_idx;
        end else begin
          ht_used_d[free_ht] = 1'b1;
          ht_id_d[free_ht]   = ar_id_i;
          ht_head_d[free_ht] = alloc_idx;
          ht_tail_d[free_ht] = alloc_idx;
        end
      end
    end

    if (flush_i) begin
      state_d   = '{default: SLOT_FREE};
      ht_used_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= '{default: SLOT_FREE};
      ht_used_q <= '0;
    end else begin
      state_q   <= state_d;
      ht_used_q <= ht_used_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_we) begin
      slot_id_q[alloc_idx] <= ar_id_i;
      addr_q[alloc_idx]    <= ar_addr_i;
      len_q[alloc_idx]     <= ar_len_i;
    end
    next_q    <= next_d;
    ht_id_q   <= ht_id_d;
    ht_head_q <= ht_head_d;
    ht_tail_q <= ht_tail_d;
  end

  assign timer_o.state      = state_q;
  assign timer_o.len        = len_q;
  assign timer_o.alloc      = alloc_vec;
  assign timer_o.first_beat = first_beat;

  // Top-level gating keeps AR out while full unless a read retires this cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_fire_i |-> !full_o || (r_fire_i && r_last_i && r_hit));

  // The list head for an R beat is a live slot of that same ID
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (r_fire_i && r_hit) |-> (state_q[r_head] != SLOT_FREE) && (slot_id_q[r_head] == r_id_i));

endmodule

`default_nettype wire

// File: rtl/phase_timer.sv
`timescale 1ns/100ps
`default_nettype none

module phase_timer #(
  parameter int unsigned MaxRdTxns = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  read_guard_pkg::cnt_t  budget_addr_i,
  input  read_guard_pkg::cnt_t  budget_data_i,
  slot_timer_if.timer_mp        timer_i
);
  import read_guard_pkg::*;

  // Budget times (len + 1) never overflows this width
  localparam int unsigned LimW = CNT_W + LEN_W + 1;

  cnt_t [MaxRdTxns-1:0]            cnt_q;
  logic [MaxRdTxns-1:0][LimW-1:0]  data_limit;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      for (int s = 0; s < MaxRdTxns; s++) begin
        // Restart on entry to either phase
        if (timer_i.alloc[s] || timer_i.first_beat[s]) begin
          cnt_q[s] <= '0;
        end else if (timer_i.state[s] == SLOT_FREE) begin
          cnt_q[s] <= '0;
        end else begin
          cnt_q[s] <= cnt_q[s] + 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int s = 0; s < MaxRdTxns; s++) begin
      data_limit[s] = LimW'(budget_data_i) * (LimW'(timer_i.len[s]) + LimW'(1));
      timer_i.timeout_data[s] = (timer_i.state[s] == SLOT_DATA) &&
                                (LimW'(cnt_q[s]) == data_limit[s]);
      timer_i.timeout[s] = timer_i.timeout_data[s] ||
                           ((timer_i.state[s] == SLOT_ADDR) && (cnt_q[s] == budget_addr_i));
    end
  end

  // A data-phase restart only comes from a slot waiting for its first beat
  for (genvar s = 0; s < MaxRdTxns; s++) begin : gen_slot_chk
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      timer_i.first_beat[s] |-> timer_i.state[s] == SLOT_ADDR);
  end

endmodule

`default_nettype wire

// File: rtl/guard_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module guard_ctrl #(
  parameter int unsigned MaxRdTxns = 4
) (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic [MaxRdTxns-1:0]                            timeout_i,
  input  logic [MaxRdTxns-1:0]                            timeout_phase_i,
  input  logic                                            unwanted_i,
  input  read_guard_pkg::addr_t                           slot_addr_i,
  input  logic                                            irq_clear_i,
  output logic [read_guard_pkg::idx_width(MaxRdTxns)-1:0] timeout_slot_o,
  output logic                                            flush_o,
  output logic                                            isolate_o,
  output logic                                            irq_o,
  output logic                                            reset_req_o,
  output read_guard_pkg::guard_cause_e                    cause_o,
  output read_guard_pkg::addr_t                           fault_addr_o
);
  import read_guard_pkg::*;

  localparam int unsigned SlotW = idx_width(MaxRdTxns);

  logic         event_q;
  guard_cause_e cause_q, cause_d;
  addr_t        fault_addr_q;
  logic         any_timeout, sel_data, new_event;

  // Lowest slot wins, so scan downwards and keep the last hit
  always_comb begin
    any_timeout    = 1'b0;
    sel_data       = 1'b0;
    timeout_slot_o = '0;
    for (int s = int'(MaxRdTxns) - 1; s >= 0; s--) begin
      if (timeout_i[s]) begin
        any_timeout    = 1'b1;
        sel_data       = timeout_phase_i[s];
        timeout_slot_o = SlotW'(s);
      end
    end
  end

  // Timeouts rank above an unwanted beat
  always_comb begin
    if (!any_timeout) begin
      cause_d = CAUSE_UNWANTED_RSP;
    end else if (sel_data) begin
      cause_d = CAUSE_DATA_TIMEOUT;
    end else begin
      cause_d = CAUSE_ADDR_TIMEOUT;
    end
  end

  // Only the first event is taken until software clears it
  assign new_event = !event_q && (any_timeout || unwanted_i);
  assign flush_o   = new_event;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      event_q      <= 1'b0;
      cause_q      <= CAUSE_NONE;
      fault_addr_q <= '0;
    end else if (event_q) begin
      if (irq_clear_i) begin
        event_q <= 1'b0;
        cause_q <= CAUSE_NONE;
      end
    end else if (new_event) begin
      event_q      <= 1'b1;
      cause_q      <= cause_d;
      fault_addr_q <= any_timeout ? slot_addr_i : '0;
    end
  end

  assign irq_o        = event_q;
  assign reset_req_o  = event_q;
  assign isolate_o    = event_q;
  assign cause_o      = cause_q;
  assign fault_addr_o = fault_addr_q;

  // Flush and isolation leave nothing new to report while an event is held
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    event_q |-> !(|timeout_i) && !unwanted_i);

endmodule

`default_nettype wire

// File: rtl/read_guard.sv
`timescale 1ns/100ps
`default_nettype none

module read_guard #(
  parameter int unsigned MaxRdTxns  = 4,
  parameter int unsigned MaxUniqIds = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Master side
  input  logic                         mst_ar_valid_i,
  output logic                         mst_ar_ready_o,
  input  read_guard_pkg::id_t          mst_ar_id_i,
  input  read_guard_pkg::addr_t        mst_ar_addr_i,
  input  read_guard_pkg::len_t         mst_ar_len_i,
  output logic                         mst_r_valid_o,
  input  logic                         mst_r_ready_i,
  output read_guard_pkg::id_t          mst_r_id_o,
  output read_guard_pkg::data_t        mst_r_data_o,
  output logic                         mst_r_last_o,
  // Slave side
  output logic                         slv_ar_valid_o,
  input  logic                         slv_ar_ready_i,
  output read_guard_pkg::id_t          slv_ar_id_o,
  output read_guard_pkg::addr_t        slv_ar_addr_o,
  output read_guard_pkg::len_t         slv_ar_len_o,
  input  logic                         slv_r_valid_i,
  output logic                         slv_r_ready_o,
  input  read_guard_pkg::id_t          slv_r_id_i,
  input  read_guard_pkg::data_t        slv_r_data_i,
  input  logic                         slv_r_last_i,
  // Budgets and event reporting
  input  read_guard_pkg::cnt_t         budget_addr_i,
  input  read_guard_pkg::cnt_t         budget_data_i,
  input  logic                         irq_clear_i,
  output logic                         irq_o,
  output logic                         reset_req_o,
  output read_guard_pkg::guard_cause_e cause_o,
  output read_guard_pkg::addr_t        fault_addr_o
);
  import read_guard_pkg::*;

  localparam int unsigned SlotW = idx_width(MaxRdTxns);

  logic             full, isolate, flush, unwanted;
  logic             ar_block, ar_fire, r_fire;
  logic [SlotW-1:0] timeout_slot;
  addr_t            slot_addr;

  slot_timer_if #(.MaxRdTxns(MaxRdTxns)) stif ();

  // AR is held off while full or isolated
  assign ar_block       = full || isolate;
  assign slv_ar_valid_o = mst_ar_valid_i && !ar_block;
  assign mst_ar_ready_o = slv_ar_ready_i && !ar_block;
  assign slv_ar_id_o    = mst_ar_id_i;
  assign slv_ar_addr_o  = mst_ar_addr_i;
  assign slv_ar_len_o   = mst_ar_len_i;

  // While isolated the slave is drained and nothing reaches the master
  assign mst_r_valid_o  = slv_r_valid_i && !isolate;
  assign slv_r_ready_o  = mst_r_ready_i || isolate;
  assign mst_r_id_o     = slv_r_id_i;
  assign mst_r_data_o   = slv_r_data_i;
  assign mst_r_last_o   = slv_r_last_i;

  assign ar_fire = slv_ar_valid_o && slv_ar_ready_i;
  assign r_fire  = slv_r_valid_i && mst_r_ready_i && !isolate;

  txn_table #(
    .MaxRdTxns  (MaxRdTxns),
    .MaxUniqIds (MaxUniqIds)
  ) u_txn_table (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ar_fire_i      (ar_fire),
    .ar_id_i        (mst_ar_id_i),
    .ar_addr_i      (mst_ar_addr_i),
    .ar_len_i       (mst_ar_len_i),
    .r_fire_i       (r_fire),
    .r_id_i         (slv_r_id_i),
    .r_last_i       (slv_r_last_i),
    .flush_i        (flush),
    .timeout_slot_i (timeout_slot),
    .full_o         (full),
    .unwanted_o     (unwanted),
    .slot_addr_o    (slot_addr),
    .timer_o        (stif.table_mp)
  );

  phase_timer #(
    .MaxRdTxns (MaxRdTxns)
  ) u_phase_timer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .budget_addr_i (budget_addr_i),
    .budget_data_i (budget_data_i),
    .timer_i       (stif.timer_mp)
  );

  guard_ctrl #(
    .MaxRdTxns (MaxRdTxns)
  ) u_guard_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .timeout_i       (stif.timeout),
    .timeout_phase_i (stif.timeout_data),
    .unwanted_i      (unwanted),
    .slot_addr_i     (slot_addr),
    .irq_clear_i     (irq_clear_i),
    .timeout_slot_o  (timeout_slot),
    .flush_o         (flush),
    .isolate_o       (isolate),
    .irq_o           (irq_o),
    .reset_req_o     (reset_req_o),
    .cause_o         (cause_o),
    .fault_addr_o    (fault_addr_o)
  );

endmodule

`default_nettype wire

// File: testbench/tb_read_guard.sv
`timescale 1ns/100ps
`default_nettype none

module tb_read_guard;
  import read_guard_pkg::*;

  localparam int unsigned MaxRdTxns  = 4;
  localparam int unsigned MaxUniqIds = 4;
  localparam time         ClkPeriod  = 100;
  localparam int          NumReads   = 40;
  localparam int          DirBudget  = 1000;
  // Every read and directed phase may take up to the largest budget
  localparam int          WdCycles   = (2 * NumReads + 10) * (DirBudget + 20);

  logic  clk_i, rst_ni;
  logic  mst_ar_valid_i, mst_ar_ready_o, mst_r_valid_o, mst_r_ready_i, mst_r_last_o;
  id_t   mst_ar_id_i, mst_r_id_o, slv_ar_id_o, slv_r_id_i;
  addr_t mst_ar_addr_i, slv_ar_addr_o, fault_addr_o;
  len_t  mst_ar_len_i, slv_ar_len_o;
  data_t mst_r_data_o, slv_r_data_i;
  logic  slv_ar_valid_o, slv_ar_ready_i, slv_r_valid_i, slv_r_ready_o, slv_r_last_i;
  cnt_t  budget_addr_i, budget_data_i;
  logic  irq_clear_i, irq_o, reset_req_o;
  guard_cause_e cause_o;

  logic [31:0] seed = 32'he235;
  int          errors = 0;
  int          beats = 0;
  int          full_cycles = 0;
  int          live = 0;
  int          issued = 0;
  // Slave model, reads in acceptance order and beats sent per ID
  id_t         q_id[$];
  len_t        q_len[$];
  int          bcnt[16];

  read_guard #(
    .MaxRdTxns  (MaxRdTxns),
    .MaxUniqIds (MaxUniqIds)
  ) UUT (
    .clk_i, .rst_ni,
    .mst_ar_valid_i, .mst_ar_ready_o, .mst_ar_id_i, .mst_ar_addr_i, .mst_ar_len_i,
    .mst_r_valid_o, .mst_r_ready_i, .mst_r_id_o, .mst_r_data_o, .mst_r_last_o,
    .slv_ar_valid_o, .slv_ar_ready_i, .slv_ar_id_o, .slv_ar_addr_o, .slv_ar_len_o,
    .slv_r_valid_i, .slv_r_ready_o, .slv_r_id_i, .slv_r_data_i, .slv_r_last_i,
    .budget_addr_i, .budget_data_i, .irq_clear_i,
    .irq_o, .reset_req_o, .cause_o, .fault_addr_o
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WdCycles * ClkPeriod);
    $display("Timeout: the run did not finish within %0d cycles", WdCycles);
    $display("*** FAILED ***");
    $finish;
  end

  function automatic logic [31:0] rand_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %s: expected %h, got %h at %0t", name, exp, got, $time);
    end
  endtask

  // Index of the oldest outstanding read of an ID
  function automatic int head_of(input id_t id);
    for (int i = 0; i < q_id.size(); i++) begin
      if (q_id[i] == id) return i;
    end
    return -1;
  endfunction

  task automatic clear_model();
    q_id.delete();
    q_len.delete();
    for (int i = 0; i < 16; i++) bcnt[i] = 0;
    live = 0;
  endtask

  task automatic idle_inputs(input cnt_t b_addr, input cnt_t b_data);
    @(posedge clk_i);
    mst_ar_valid_i <= 1'b0;
    mst_r_ready_i  <= 1'b0;
    slv_ar_ready_i <= 1'b1;
    slv_r_valid_i  <= 1'b0;
    slv_r_last_i   <= 1'b0;
    irq_clear_i    <= 1'b0;
    budget_addr_i  <= b_addr;
    budget_data_i  <= b_data;
  endtask

  // One cycle of random traffic, checked at the falling edge
  task automatic traffic_cycle(input int target);
    logic ar_fire, r_fire;
    int   i, j;
    id_t  rid;
    @(negedge clk_i);
    ar_fire = mst_ar_valid_i && slv_ar_ready_i && (live < MaxRdTxns);
    r_fire  = slv_r_valid_i && mst_r_ready_i;
    check_val("mst_ar_ready_o", mst_ar_ready_o, slv_ar_ready_i && (live < MaxRdTxns));
    check_val("slv_ar_valid_o", slv_ar_valid_o, mst_ar_valid_i && (live < MaxRdTxns));
    if (mst_ar_valid_i) begin
      check_val("slv_ar_id_o", slv_ar_id_o, mst_ar_id_i);
      check_val("slv_ar_addr_o", slv_ar_addr_o, mst_ar_addr_i);
      check_val("slv_ar_len_o", slv_ar_len_o, mst_ar_len_i);
    end
    if (live == MaxRdTxns && mst_ar_valid_i) full_cycles++;
    check_val("mst_r_valid_o", mst_r_valid_o, slv_r_valid_i);
    check_val("slv_r_ready_o", slv_r_ready_o, mst_r_ready_i);
    if (slv_r_valid_i) begin
      check_val("mst_r_id_o", mst_r_id_o, slv_r_id_i);
      check_val("mst_r_data_o", mst_r_data_o, slv_r_data_i);
      check_val("mst_r_last_o", mst_r_last_o, slv_r_last_i);
    end
    check_val("irq_o", irq_o, 1'b0);
    @(posedge clk_i);
    if (ar_fire) begin
      q_id.push_back(mst_ar_id_i);
      q_len.push_back(mst_ar_len_i);
      live++;
      issued++;
    end
    if (r_fire) begin
      beats++;
      j = head_of(slv_r_id_i);
      bcnt[slv_r_id_i]++;
      if (slv_r_last_i && j >= 0) begin
        q_id.delete(j);
        q_len.delete(j);
        bcnt[slv_r_id_i] = 0;
        live--;
      end
    end
    if (!mst_ar_valid_i || ar_fire) begin
      if (issued < target && rand_next() % 3 != 0) begin
        mst_ar_valid_i <= 1'b1;
        mst_ar_id_i    <= id_t'(rand_next() % 4);
        mst_ar_addr_i  <= rand_next() & 32'hffff_fffc;
        mst_ar_len_i   <= len_t'(rand_next() % 4);
      end else begin
        mst_ar_valid_i <= 1'b0;
      end
    end
    slv_ar_ready_i <= (rand_next() % 4 != 0);
    mst_r_ready_i  <= (rand_next() % 4 != 0);
    // Any ID may be picked per beat, so IDs interleave
    if (!slv_r_valid_i || r_fire) begin
      if (q_id.size() > 0 && rand_next() % 2 == 0) begin
        i   = int'(rand_next() % q_id.size());
        rid = q_id[i];
        j   = head_of(rid);
        slv_r_valid_i <= 1'b1;
        slv_r_id_i    <= rid;
        slv_r_data_i  <= rand_next();
        slv_r_last_i  <= (bcnt[rid] == int'(q_len[j]));
      end else begin
        slv_r_valid_i <= 1'b0;
      end
    end
  endtask

  task automatic run_traffic(input int n);
    idle_inputs(16'hffff, 16'hffff);
    issued = 0;
    while (issued < n || live > 0) traffic_cycle(n);
    idle_inputs(16'hffff, 16'hffff);
  endtask

  // Returns just after the edge of the AR handshake
  task automatic send_ar(input id_t id, input addr_t addr, input len_t len);
    @(posedge clk_i);
    mst_ar_valid_i <= 1'b1;
    mst_ar_id_i    <= id;
    mst_ar_addr_i  <= addr;
    mst_ar_len_i   <= len;
    do @(negedge clk_i); while (!mst_ar_ready_o);
    @(posedge clk_i);
    mst_ar_valid_i <= 1'b0;
  endtask

  // Counter starts at zero after the current edge, event is seen one edge after the match
  task automatic expect_irq_after(input int limit);
    for (int k = 0; k <= limit + 1; k++) begin
      @(negedge clk_i);
      check_val("irq_o", irq_o, k > limit);
      check_val("reset_req_o", reset_req_o, k > limit);
      if (k <= limit) @(posedge clk_i);
    end
  endtask

  task automatic isolate_and_clear();
    @(posedge clk_i);
    mst_ar_valid_i <= 1'b1;
    slv_r_valid_i  <= 1'b1;
    slv_r_id_i     <= 4'h3;
    mst_r_ready_i  <= 1'b0;
    @(negedge clk_i);
    check_val("reset_req_o", reset_req_o, 1'b1);
    check_val("slv_ar_valid_o", slv_ar_valid_o, 1'b0);
    check_val("mst_ar_ready_o", mst_ar_ready_o, 1'b0);
    check_val("mst_r_valid_o", mst_r_valid_o, 1'b0);
    check_val("slv_r_ready_o", slv_r_ready_o, 1'b1);
    @(posedge clk_i);
    mst_ar_valid_i <= 1'b0;
    slv_r_valid_i  <= 1'b0;
    irq_clear_i    <= 1'b1;
    @(posedge clk_i);
    irq_clear_i    <= 1'b0;
    @(negedge clk_i);
    check_val("irq_o", irq_o, 1'b0);
    check_val("reset_req_o", reset_req_o, 1'b0);
    check_val("cause_o", cause_o, CAUSE_NONE);
    check_val("slv_r_ready_o", slv_r_ready_o, 1'b0);
    clear_model();
  endtask

  initial begin
    rst_ni = 1'b0;
    mst_ar_valid_i = 1'b0;
    mst_ar_id_i = '0;
    mst_ar_addr_i = '0;
    mst_ar_len_i = '0;
    mst_r_ready_i = 1'b0;
    slv_ar_ready_i = 1'b0;
    slv_r_valid_i = 1'b0;
    slv_r_id_i = '0;
    slv_r_data_i = '0;
    slv_r_last_i = 1'b0;
    budget_addr_i = 16'hffff;
    budget_data_i = 16'hffff;
    irq_clear_i = 1'b0;
    clear_model();
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_val("irq_o", irq_o, 1'b0);
    check_val("cause_o", cause_o, CAUSE_NONE);

    run_traffic(NumReads);
    assert (full_cycles > 0) else begin
      errors++;
      $display("Back-pressure was never reached during random traffic");
    end

    // Address phase timeout on a withheld first beat
    idle_inputs(16'd20, DirBudget);
    send_ar(4'h2, 32'h1000_2a40, 8'd0);
    expect_irq_after(20);
    check_val("cause_o", cause_o, CAUSE_ADDR_TIMEOUT);
    check_val("fault_addr_o", fault_addr_o, 32'h1000_2a40);
    isolate_and_clear();

    // Data phase stall after the first of three beats
    idle_inputs(DirBudget, 16'd5);
    send_ar(4'h1, 32'h0000_7f10, 8'd2);
    @(posedge clk_i);
    slv_r_valid_i <= 1'b1;
    slv_r_id_i    <= 4'h1;
    slv_r_last_i  <= 1'b0;
    mst_r_ready_i <= 1'b1;
    @(posedge clk_i);
    slv_r_valid_i <= 1'b0;
    expect_irq_after(5 * 3);
    check_val("cause_o", cause_o, CAUSE_DATA_TIMEOUT);
    check_val("fault_addr_o", fault_addr_o, 32'h0000_7f10);
    isolate_and_clear();

    // Beat for an ID with nothing outstanding
    idle_inputs(DirBudget, DirBudget);
    @(posedge clk_i);
    slv_r_valid_i <= 1'b1;
    slv_r_id_i    <= 4'h9;
    slv_r_last_i  <= 1'b1;
    mst_r_ready_i <= 1'b1;
    @(negedge clk_i);
    check_val("irq_o", irq_o, 1'b0);
    @(posedge clk_i);
    slv_r_valid_i <= 1'b0;
    @(negedge clk_i);
    check_val("irq_o", irq_o, 1'b1);
    check_val("cause_o", cause_o, CAUSE_UNWANTED_RSP);
    isolate_and_clear();

    run_traffic(NumReads / 2);

    $display("Beats: %0d, full cycles: %0d, errors: %0d", beats, full_cycles, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
rtl/read_guard_pkg.sv
rtl/slot_timer_if.sv
rtl/txn_table.sv
rtl/phase_timer.sv
rtl/guard_ctrl.sv
rtl/read_guard.sv
testbench/tb_read_guard.sv
